//--- all.f
apnpsf_pkg.sv
apnpsf_pattern_rom.sv
apnpsf_sequencer.sv
apnpsf_expect_fifo.sv
apnpsf_read_checker.sv
apnpsf_bist_top.sv
tb_clock_gen.sv
tb_mem_model.sv
tb_apnpsf.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_apnpsf
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_apnpsf.sv
// NPSF BIST testbench
`timescale 1ns/1ps
`default_nettype none

module tb_apnpsf;
    import apnpsf_pkg::*;

    localparam int min_addr_bits = 4;
    localparam int mem_credits   = 4;
    localparam int n_tests       = 11;
    localparam int test_depth [n_tests] = '{0, 1, 0, 1, 1, 0, 0, 1, 1, 1, 1};
    // step table, pattern index 0 zero, 1 bg, 2 a, 3 b
    localparam int step_off [8] = '{0, -1, 0, 0, -1, 1, 0, 1};
    localparam bit step_wr [8]  = '{1, 1, 0, 1, 0, 1, 0, 0};
    localparam int step_pat [8] = '{0, 1, 0, 2, 1, 3, 2, 3};

    logic        clk;
    logic        rst_n;
    logic        start;
    mem_cfg_t    cfg;
    nbr_group_t  nbr_group;
    addr_t       allowable_faulty;
    logic        error_exceed_ignore;
    logic        busy;
    logic        done;
    logic        error;
    addr_t       error_count;
    logic        force_terminate;
    mem_req_t    req;
    logic        req_valid;
    logic        credit_return;
    logic        rsp_valid;
    data_t       rsp_data;
    logic        withhold;
    logic        fault_en;
    addr_t       fault_addr;
    data_t       stuck_mask;
    data_t       stuck_val;
    data_t       corrupt_mask;
    mem_req_t    exp_reqs [$];
    int          n_issued;
    int          err_pulses;
    int          outstanding;
    int          errors;
    int          checks;
    int          cycles;
    int          cycle_limit;

    tb_clock_gen #(.period_ns(20), .reset_cycles(5)) u_clock_gen (.clk(clk), .rst_n(rst_n));

    tb_mem_model #(
        .depth (1 << (min_addr_bits + 7))
    ) u_mem_model (
        .clk           (clk),
        .req           (req),
        .req_valid     (req_valid),
        .withhold      (withhold),
        .fault_en      (fault_en),
        .fault_addr    (fault_addr),
        .stuck_mask    (stuck_mask),
        .stuck_val     (stuck_val),
        .corrupt_mask  (corrupt_mask),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data)
    );

    apnpsf_bist_top #(
        .min_addr_bits (min_addr_bits),
        .mem_credits   (mem_credits)
    ) u_apnpsf_bist_top (
        .clk                 (clk),
        .rst_n               (rst_n),
        .start               (start),
        .cfg                 (cfg),
        .nbr_group           (nbr_group),
        .allowable_faulty    (allowable_faulty),
        .error_exceed_ignore (error_exceed_ignore),
        .busy                (busy),
        .done                (done),
        .error               (error),
        .error_count         (error_count),
        .force_terminate     (force_terminate),
        .req                 (req),
        .req_valid           (req_valid),
        .credit_return       (credit_return),
        .rsp_valid           (rsp_valid),
        .rsp_data            (rsp_data)
    );

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    function automatic data_t apply_stuck(input addr_t a, input data_t d);
        if (fault_en && a == fault_addr) begin
            return (d & ~stuck_mask) | (stuck_val & stuck_mask);
        end
        return d;
    endfunction

    // replays fill and the step table, fills exp_reqs, returns the mismatch count
    function automatic int ref_run(input mem_cfg_t c, input nbr_group_t g, output int n_req);
        int       depth;
        int       errs;
        int       a;
        mem_req_t r;
        data_t    d;
        data_t    wmask;
        data_t    pats [4];
        data_t    sw_mem [];
        depth = 1 << (min_addr_bits + int'(c.depth_code));
        wmask = (c.width_code == 2'd3) ? '1 : (data_t'(1) << (8 << c.width_code)) - 1;
        pats = '{data_t'(0), pat_bg[g], pat_a[g], pat_b[g]};
        sw_mem = new[depth];
        errs = 0;
        exp_reqs.delete();
        for (int i = 0; i < depth; i++) begin
            r = '{write: 1'b1, addr: addr_t'(i), wdata: data_t'(0)};
            exp_reqs.push_back(r);
            sw_mem[i] = apply_stuck(addr_t'(i), '0);
        end
        for (int base = 0; base < depth; base += 4) begin
            for (int s = 0; s < 8; s++) begin
                a = (base + step_off[s] + depth) % depth;
                d = pats[step_pat[s]];
                r = '{write: step_wr[s], addr: addr_t'(a), wdata: d};
                exp_reqs.push_back(r);
                if (step_wr[s]) begin
                    sw_mem[a] = apply_stuck(addr_t'(a), d);
                end else if ((((sw_mem[a] ^ corrupt_mask) ^ d) & wmask) != '0) begin
                    errs++;
                end
            end
        end
        n_req = exp_reqs.size();
        return errs;
    endfunction

    function automatic int total_requests();
        int sum;
        sum = 0;
        for (int i = 0; i < n_tests; i++) begin
            sum += 3 * (1 << (min_addr_bits + test_depth[i])); // fill plus 8 per 4 words
        end
        return sum;
    endfunction

    task automatic set_faults(input logic en, input addr_t a, input data_t m, input data_t v,
                              input data_t corrupt, input logic hold);
        fault_en     = en;
        fault_addr   = a;
        stuck_mask   = m;
        stuck_val    = v;
        corrupt_mask = corrupt;
        withhold     = hold;
    endtask

    task automatic run_test(input int idx, input string name, input nbr_group_t g,
                            input width_code_t w, input addr_t allow, input logic ignore,
                            input logic abort_expected);
        int exp_errs;
        int n_req;
        int errs_before;
        errs_before = errors;
        @(negedge clk);
        cfg.depth_code      = depth_code_t'(test_depth[idx]);
        cfg.width_code      = w;
        nbr_group           = g;
        allowable_faulty    = allow;
        error_exceed_ignore = ignore;
        exp_errs            = ref_run(cfg, g, n_req);
        n_issued            = 0;
        err_pulses          = 0;
        start               = 1'b1;
        @(negedge clk);
        start = 1'b0;
        compare("busy", 64'(1), 64'(busy));
        compare("done", 64'(0), 64'(done));
        while (!done) begin
            @(negedge clk);
        end
        compare("busy", 64'(0), 64'(busy));
        compare("error pulses", 64'(error_count), 64'(err_pulses));
        compare("force_terminate", 64'(abort_expected), 64'(force_terminate));
        if (abort_expected) begin
            if (n_issued >= n_req) begin
                report_failure("abort did not cut the request stream short");
            end
            if (int'(error_count) <= int'(allow) || int'(error_count) > exp_errs) begin
                report_failure("error_count of the aborted run is out of range");
            end
        end else begin
            compare("request count", 64'(n_req), 64'(n_issued));
            compare("error_count", 64'(exp_errs), 64'(error_count));
        end
        $display("test %0d %s %s", idx, name, (errors == errs_before) ? "ok" : "FAILED");
    endtask

    // request, error and credit monitor, sampled before the DUT updates
    always @(posedge clk) begin
        if (rst_n) begin
            cycles++;
            if (error) begin
                err_pulses++;
            end
            outstanding = outstanding + int'(req_valid) - int'(credit_return);
            if (outstanding > mem_credits) begin
                report_failure("more requests outstanding than credits");
            end
            if (req_valid && n_issued < exp_reqs.size()) begin
                compare("req.write", 64'(exp_reqs[n_issued].write), 64'(req.write));
                compare("req.addr", 64'(exp_reqs[n_issued].addr), 64'(req.addr));
                if (req.write) begin
                    compare("req.wdata", exp_reqs[n_issued].wdata, req.wdata);
                end
            end else if (req_valid) begin
                report_failure("request issued beyond the expected sequence");
            end
            if (req_valid) begin
                n_issued++;
            end
            if (cycles >= cycle_limit) begin
                $display("TIMEOUT after %0d cycles, the run did not finish", cycles);
                $display("Regression failed");
                $finish;
            end
        end
    end

    initial begin
        start               = 1'b0;
        cfg                 = '0;
        nbr_group           = '0;
        allowable_faulty    = '1;
        error_exceed_ignore = 1'b0;
        set_faults(1'b0, '0, '0, '0, '0, 1'b0);
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        n_issued    = 0;
        err_pulses  = 0;
        outstanding = 0;
        void'($urandom(74));
        cycle_limit = 2 * total_requests() * 5 + 1000;
        wait (rst_n === 1'b1);
        @(negedge clk);
        compare("req_valid", 64'(0), 64'(req_valid));
        compare("busy", 64'(0), 64'(busy));
        compare("done", 64'(0), 64'(done));
        compare("error", 64'(0), 64'(error));
        compare("error_count", 64'(0), 64'(error_count));
        $display("test reset %s %s", "idle_outputs", (errors == 0) ? "ok" : "FAILED");
        run_test(0, "clean_g0", 2'd0, 2'd3, '1, 1'b0, 1'b0);
        run_test(1, "clean_g1", 2'd1, 2'd3, '1, 1'b0, 1'b0);
        run_test(2, "clean_g2", 2'd2, 2'd3, '1, 1'b0, 1'b0);
        run_test(3, "clean_g3", 2'd3, 2'd3, '1, 1'b0, 1'b0);
        set_faults(1'b1, 16'd4, 64'h1, 64'h1, '0, 1'b0); // bit 0 stuck at one
        run_test(4, "stuck_at", 2'd2, 2'd3, '1, 1'b0, 1'b0);
        set_faults(1'b0, '0, '0, '0, 64'hFF00, 1'b0);
        run_test(5, "width_upper", 2'd0, 2'd0, '1, 1'b0, 1'b0);
        set_faults(1'b0, '0, '0, '0, 64'h80, 1'b0);
        run_test(6, "width_low", 2'd0, 2'd0, '1, 1'b0, 1'b0);
        set_faults(1'b1, 16'd4, 64'h1, 64'h1, '0, 1'b0);
        run_test(7, "abort", 2'd2, 2'd3, 16'd0, 1'b0, 1'b1);
        run_test(8, "abort_ignored", 2'd2, 2'd3, 16'd0, 1'b1, 1'b0);
        set_faults(1'b0, '0, '0, '0, '0, 1'b1);
        run_test(9, "credit_clean", 2'd3, 2'd3, '1, 1'b0, 1'b0);
        set_faults(1'b1, 16'd4, 64'h1, 64'h1, '0, 1'b1);
        run_test(10, "credit_stuck", 2'd2, 2'd3, '1, 1'b0, 1'b0);
        $display("tests %0d, checks %0d, errors %0d", n_tests + 1, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_mem_model.sv
// Behavioral memory with credit return
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
    parameter int depth = 2048
) (
    input  wire                       clk,
    input  wire apnpsf_pkg::mem_req_t req,
    input  wire                       req_valid,
    input  wire                       withhold,
    input  wire                       fault_en,
    input  wire apnpsf_pkg::addr_t    fault_addr,
    input  wire apnpsf_pkg::data_t    stuck_mask,
    input  wire apnpsf_pkg::data_t    stuck_val,
    input  wire apnpsf_pkg::data_t    corrupt_mask,
    output logic                      credit_return,
    output logic                      rsp_valid,
    output apnpsf_pkg::data_t         rsp_data
);
    import apnpsf_pkg::*;

    data_t store [depth];
    logic  pend_read [$]; // one entry per request, issue order
    data_t pend_data [$];
    int    pend_due [$];
    int    head;
    int    cyc;

    initial begin
        credit_return = 1'b0;
        rsp_valid     = 1'b0;
        rsp_data      = '0;
        head          = 0;
        cyc           = 0;
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (req_valid) begin
            if (req.write && fault_en && req.addr == fault_addr) begin
                store[req.addr] = (req.wdata & ~stuck_mask) | (stuck_val & stuck_mask);
            end else if (req.write) begin
                store[req.addr] = req.wdata;
            end
            pend_read.push_back(!req.write);
            pend_data.push_back(store[req.addr] ^ corrupt_mask); // data as of issue
            pend_due.push_back(cyc + 1 + int'($urandom % 4));
        end
    end

    // at most one completion per cycle, strictly in order
    always @(negedge clk) begin
        credit_return <= 1'b0;
        rsp_valid     <= 1'b0;
        if (head < pend_due.size() && pend_due[head] <= cyc) begin
            if (!withhold || ($urandom % 2) == 1) begin // random hold-back
                credit_return <= 1'b1;
                rsp_valid     <= pend_read[head];
                rsp_data      <= pend_data[head];
                head          <= head + 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk); // release away from the active edge
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- apnpsf_bist_top.sv
// NPSF memory BIST top
`timescale 1ns/1ps
`default_nettype none

module apnpsf_bist_top #(
    parameter int min_addr_bits = 9,
    parameter int mem_credits   = 4
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         start,
    input  wire apnpsf_pkg::mem_cfg_t   cfg,
    input  wire apnpsf_pkg::nbr_group_t nbr_group,
    input  wire apnpsf_pkg::addr_t      allowable_faulty,
    input  wire                         error_exceed_ignore,
    output logic                        busy,
    output logic                        done,
    output logic                        error,
    output apnpsf_pkg::addr_t           error_count,
    output logic                        force_terminate,
    output apnpsf_pkg::mem_req_t        req,
    output logic                        req_valid,
    input  wire                         credit_return,
    input  wire                         rsp_valid,
    input  wire apnpsf_pkg::data_t      rsp_data
);
    import apnpsf_pkg::*;

    logic  exp_push;
    data_t exp_data;

    apnpsf_sequencer #(
        .min_addr_bits (min_addr_bits),
        .mem_credits   (mem_credits)
    ) u_sequencer (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (start),
        .cfg             (cfg), // depth field used here
        .nbr_group       (nbr_group),
        .force_terminate (force_terminate),
        .credit_return   (credit_return),
        .req             (req),
        .req_valid       (req_valid),
        .exp_push        (exp_push),
        .exp_data        (exp_data),
        .busy            (busy),
        .done            (done)
    );

    apnpsf_read_checker #(
        .mem_credits (mem_credits)
    ) u_read_checker (
        .clk                 (clk),
        .rst_n               (rst_n),
        .start               (start),
        .width_code          (cfg.width_code),
        .exp_push            (exp_push),
        .exp_data            (exp_data),
        .rsp_valid           (rsp_valid),
        .rsp_data            (rsp_data),
        .allowable_faulty    (allowable_faulty),
        .error_exceed_ignore (error_exceed_ignore),
        .error               (error),
        .error_count         (error_count),
        .force_terminate     (force_terminate)
    );

endmodule

`default_nettype wire

//--- apnpsf_read_checker.sv
// NPSF read data checker
`timescale 1ns/1ps
`default_nettype none

module apnpsf_read_checker #(
    parameter int mem_credits = 4
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          start,
    input  wire apnpsf_pkg::width_code_t width_code,
    input  wire                          exp_push,
    input  wire apnpsf_pkg::data_t       exp_data,
    input  wire                          rsp_valid,
    input  wire apnpsf_pkg::data_t       rsp_data,
    input  wire apnpsf_pkg::addr_t       allowable_faulty,
    input  wire                          error_exceed_ignore,
    output logic                         error,
    output apnpsf_pkg::addr_t            error_count,
    output logic                         force_terminate
);
    import apnpsf_pkg::*;

    data_t exp_head;
    data_t cmp_mask;
    logic  mismatch;

    apnpsf_expect_fifo #(
        .depth (mem_credits)
    ) u_expect_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (exp_push),
        .push_data (exp_data),
        .pop       (rsp_valid),
        .pop_data  (exp_head)
    );

    always_comb begin
        case (width_code)
            2'b00:   cmp_mask = data_t'({8{1'b1}});
            2'b01:   cmp_mask = data_t'({16{1'b1}});
            2'b10:   cmp_mask = data_t'({32{1'b1}});
            default: cmp_mask = '1;
        endcase
    end

    assign mismatch = |((rsp_data ^ exp_head) & cmp_mask); // upper bits ignored

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            error       <= 1'b0;
            error_count <= '0;
        end else begin
            error <= rsp_valid && mismatch;
            if (start) begin
                error_count <= '0;
            end else if (rsp_valid && mismatch && error_count != '1) begin
                error_count <= error_count + 1'b1; // saturates
            end
        end
    end

    assign force_terminate = !error_exceed_ignore && (error_count > allowable_faulty);

endmodule

`default_nettype wire

//--- apnpsf_expect_fifo.sv
// Expected read data FIFO
`timescale 1ns/1ps
`default_nettype none

module apnpsf_expect_fifo #(
    parameter int depth = 4
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    push,
    input  wire apnpsf_pkg::data_t push_data,
    input  wire                    pop,
    output apnpsf_pkg::data_t      pop_data
);
    import apnpsf_pkg::*;

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    data_t            mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;

    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- apnpsf_sequencer.sv
// NPSF request sequencer
`timescale 1ns/1ps
`default_nettype none

module apnpsf_sequencer #(
    parameter int min_addr_bits = 9,
    parameter int mem_credits   = 4
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         start,
    input  wire apnpsf_pkg::mem_cfg_t   cfg,
    input  wire apnpsf_pkg::nbr_group_t nbr_group,
    input  wire                         force_terminate,
    input  wire                         credit_return,
    output apnpsf_pkg::mem_req_t        req,
    output logic                        req_valid,
    output logic                        exp_push,
    output apnpsf_pkg::data_t           exp_data,
    output logic                        busy,
    output logic                        done
);
    import apnpsf_pkg::*;

    localparam int cred_w = $clog2(mem_credits + 1);

    typedef enum logic [2:0] {st_idle, st_fill, st_test, st_drain, st_done} phase_t;

    phase_t            state;
    logic [cred_w-1:0] credits;
    addr_t             addr_cnt; // fill address, then test base
    step_t             step;
    mem_op_t           op;
    logic [addr_w:0]   span;
    addr_t             depth_mask;
    addr_t             op_addr;
    logic              issue;

    apnpsf_pattern_rom u_pattern_rom (
        .step      (step),
        .nbr_group (nbr_group),
        .op        (op)
    );

    assign span       = (addr_w + 1)'(1) << (min_addr_bits + int'(cfg.depth_code));
    assign depth_mask = addr_t'(span - 1'b1);

    always_comb begin
        case (op.offset)
            nbr_left:  op_addr = (addr_cnt - 1'b1) & depth_mask; // wraps to depth-1
            nbr_right: op_addr = (addr_cnt + 1'b1) & depth_mask;
            default:   op_addr = addr_cnt;
        endcase
    end

    assign issue = (state == st_fill || state == st_test) && credits != '0 && !force_terminate;

    always_comb begin
        if (state == st_test) begin
            req.write = op.write;
            req.addr  = op_addr;
            req.wdata = op.data;
        end else begin
            req.write = 1'b1; // zero fill
            req.addr  = addr_cnt;
            req.wdata = '0;
        end
    end

    assign req_valid = issue;
    assign exp_push  = issue && state == st_test && !op.write;
    assign exp_data  = op.data;
    assign busy      = state == st_fill || state == st_test || state == st_drain;
    assign done      = state == st_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= cred_w'(mem_credits);
        end else begin
            credits <= credits - cred_w'(issue) + cred_w'(credit_return);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            addr_cnt <= '0;
            step     <= '0;
        end else begin
            case (state)
                st_idle, st_done: begin
                    if (start) begin
                        state    <= st_fill;
                        addr_cnt <= '0;
                        step     <= '0;
                    end
                end
                st_fill: begin
                    if (force_terminate) begin
                        state <= st_drain;
                    end else if (issue) begin
                        if (addr_cnt == depth_mask) begin
                            state    <= st_test;
                            addr_cnt <= '0;
                        end else begin
                            addr_cnt <= addr_cnt + 1'b1;
                        end
                    end
                end
                st_test: begin
                    if (force_terminate) begin
                        state <= st_drain;
                    end else if (issue) begin
                        step <= step + 1'b1; // 7 wraps to 0
                        if (step == step_t'(7)) begin
                            if (addr_cnt == depth_mask - addr_t'(3)) begin
                                state <= st_drain;
                            end else begin
                                addr_cnt <= addr_cnt + addr_t'(4);
                            end
                        end
                    end
                end
                st_drain: begin
                    if (credits == cred_w'(mem_credits)) begin
                        state <= st_done; // all writes acked, all reads back
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- apnpsf_pattern_rom.sv
// NPSF test step table
`timescale 1ns/1ps
`default_nettype none

module apnpsf_pattern_rom (
    input  wire apnpsf_pkg::step_t      step,
    input  wire apnpsf_pkg::nbr_group_t nbr_group,
    output apnpsf_pkg::mem_op_t         op
);
    import apnpsf_pkg::*;

    always_comb begin
        op.write  = 1'b0;
        op.offset = nbr_victim;
        op.data   = '0;
        case (step)
            3'd0: begin
                op.write = 1'b1; // clear victim
            end
            3'd1: begin
                op.write  = 1'b1;
                op.offset = nbr_left;
                op.data   = pat_bg[nbr_group];
            end
            3'd2: begin
                op.data = '0; // victim must stay zero
            end
            3'd3: begin
                op.write = 1'b1;
                op.data  = pat_a[nbr_group];
            end
            3'd4: begin
                op.offset = nbr_left;
                op.data   = pat_bg[nbr_group]; // active write on victim must not disturb
            end
            3'd5: begin
                op.write  = 1'b1;
                op.offset = nbr_right;
                op.data   = pat_b[nbr_group];
            end
            3'd6: begin
                op.data = pat_a[nbr_group];
            end
            default: begin
                op.offset = nbr_right;
                op.data   = pat_b[nbr_group];
            end
        endcase
    end

endmodule

`default_nettype wire

//--- apnpsf_pkg.sv
// NPSF self-test shared types
`default_nettype none

package apnpsf_pkg;

    localparam int data_w = 64;
    localparam int addr_w = 16;

    typedef logic [data_w-1:0] data_t;
    typedef logic [addr_w-1:0] addr_t;

    typedef logic [1:0] width_code_t; // 8, 16, 32, 64 bits
    typedef logic [2:0] depth_code_t; // depth = 2**(min_addr_bits + code)
    typedef logic [1:0] nbr_group_t;
    typedef logic [2:0] step_t;

    typedef struct packed {
        depth_code_t depth_code;
        width_code_t width_code;
    } mem_cfg_t;

    typedef enum logic [1:0] {
        nbr_victim = 2'd0,
        nbr_left   = 2'd1, // address minus one
        nbr_right  = 2'd2  // address plus one
    } nbr_offset_t;

    typedef struct packed {
        logic        write;
        nbr_offset_t offset;
        data_t       data; // write data or expected read data
    } mem_op_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    // one entry per neighbour group
    localparam data_t pat_bg [4] = '{
        64'h8888_8888_8888_8888, 64'h4444_4444_4444_4444,
        64'h2222_2222_2222_2222, 64'h1111_1111_1111_1111
    };

    localparam data_t pat_a [4] = '{
        64'hCCCC_CCCC_CCCC_CCCC, 64'h6666_6666_6666_6666,
        64'h3333_3333_3333_3333, 64'h9999_9999_9999_9999
    };

    localparam data_t pat_b [4] = '{
        64'hAAAA_AAAA_AAAA_AAAA, 64'h5555_5555_5555_5555,
        64'h2A2A_2A2A_2A2A_2A2A, 64'h3B3B_3B3B_3B3B_3B3B
    };

endpackage

`default_nettype wire
